//--- include/vcache_defines.svh
// vertical cache tile widths and sizes
// shared by the tile, the link adapter and the cache

`ifndef VCACHE_DEFINES_SVH
`define VCACHE_DEFINES_SVH

// word address and data word
`define VCACHE_ADDR_WIDTH 10
`define VCACHE_DATA_WIDTH 32

// cache geometry
`define VCACHE_SETS 8
`define VCACHE_BLOCK_WORDS 4

// network side tags and tile coordinates
`define VCACHE_SRC_WIDTH 4
`define VCACHE_CORD_WIDTH 6

// request buffer depth
`define VCACHE_FIFO_ELS 4

// packed request word: opcode, address, data, source tag
`define VCACHE_REQ_WIDTH ($bits(vcache_pkg::vcache_opcode_e) + `VCACHE_ADDR_WIDTH \
  + `VCACHE_DATA_WIDTH + `VCACHE_SRC_WIDTH)

// one whole block on the dma port, addressed by block number
`define VCACHE_BLOCK_WIDTH (`VCACHE_BLOCK_WORDS * `VCACHE_DATA_WIDTH)
`define VCACHE_BLOCK_ADDR_WIDTH (`VCACHE_ADDR_WIDTH - $clog2(`VCACHE_BLOCK_WORDS))

`endif

//--- verilog/vcache_pkg.sv
// vertical cache types
// request opcodes and the cache controller states

package vcache_pkg;

  // network request opcodes
  // atomics return the old word
  typedef enum logic [2:0] {
    OP_LW      = 3'd0,
    OP_SW      = 3'd1,
    OP_AMOADD  = 3'd2,
    OP_AMOOR   = 3'd3,
    OP_AMOSWAP = 3'd4
  } vcache_opcode_e;

  // cache controller
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    EVICT     = 3'd2,
    FILL_REQ  = 3'd3,
    FILL_WAIT = 3'd4,
    RESPOND   = 3'd5
  } vcache_state_e;

endpackage

//--- verilog/vcache_req_fifo.sv
// request buffer between the link adapter and the cache
// circular buffer with read/write pointers and an occupancy count;
// head is presented without delay, and a full buffer still accepts
// a write in the cycle its head is popped

`timescale 1ns/1ns

module vcache_req_fifo #(
  parameter int width_p = 8
  , parameter int els_p = 4
) (
  input  logic               clk_i
  , input  logic             reset_i

  // write side, v/ready
  , input  logic             v_i
  , input  logic [width_p-1:0] data_i
  , output logic             ready_o

  // read side, v/yumi
  , output logic             v_o
  , output logic [width_p-1:0] data_o
  , input  logic             yumi_i
);

  localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int count_width_lp = $clog2(els_p + 1);

  logic [width_p-1:0]        mem_r [els_p];
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic [count_width_lp-1:0] count_n;
  logic                      ready_r;
  logic                      push;
  logic                      pop;

  // wrap at els_p, depth need not be a power of two
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(els_p - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  // ready_r is the registered not-full flag;
  // a pop frees a slot in the same cycle
  assign ready_o = ready_r | yumi_i;
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  assign v_o    = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_comb begin
    count_n = count_r;
    if (push & ~pop) begin
      count_n = count_r + 1'b1;
    end else if (pop & ~push) begin
      count_n = count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
      ready_r  <= 1'b0;
    end else begin
      if (push) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop) rd_ptr_r <= next_ptr(rd_ptr_r);
      count_r <= count_n;
      ready_r <= (count_n != count_width_lp'(els_p));
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- verilog/vcache_link_to_cache.sv
// network side adapter for the vertical cache
// packs accepted requests into the request FIFO word and returns
// one response per request, in order, through a one-entry response
// register that absorbs network back-pressure

`timescale 1ns/1ns
`include "vcache_defines.svh"

module vcache_link_to_cache (
  input  logic                           clk_i
  , input  logic                         reset_i

  // network requests
  , input  logic                         req_v_i
  , input  vcache_pkg::vcache_opcode_e   req_op_i
  , input  logic [`VCACHE_ADDR_WIDTH-1:0] req_addr_i
  , input  logic [`VCACHE_DATA_WIDTH-1:0] req_data_i
  , input  logic [`VCACHE_SRC_WIDTH-1:0]  req_src_i
  , output logic                         req_ready_o

  // to the request FIFO
  , output logic                         fifo_v_o
  , output logic [`VCACHE_REQ_WIDTH-1:0] fifo_data_o
  , input  logic                         fifo_ready_i

  // results from the cache
  , input  logic                         cache_v_i
  , input  logic [`VCACHE_DATA_WIDTH-1:0] cache_data_i
  , input  logic [`VCACHE_SRC_WIDTH-1:0]  cache_src_i
  , output logic                         cache_yumi_o

  // network responses
  , output logic                         resp_v_o
  , output logic [`VCACHE_DATA_WIDTH-1:0] resp_data_o
  , output logic [`VCACHE_SRC_WIDTH-1:0]  resp_src_o
  , input  logic                         resp_yumi_i
);

  logic                          resp_v_r;
  logic [`VCACHE_DATA_WIDTH-1:0] resp_data_r;
  logic [`VCACHE_SRC_WIDTH-1:0]  resp_src_r;

  // request side
  // every accepted request goes straight into the FIFO,
  // so the network sees FIFO space as its ready
  assign fifo_v_o    = req_v_i;
  assign fifo_data_o = {req_op_i, req_addr_i, req_data_i, req_src_i};
  assign req_ready_o = fifo_ready_i;

  // take a cache result when the response slot is free or draining now
  assign cache_yumi_o = cache_v_i & (~resp_v_r | resp_yumi_i);

  // response slot occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (cache_yumi_o) begin
      resp_v_r <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_r <= 1'b0;
    end
  end

  // payload only changes on a new result, held while waiting
  always_ff @(posedge clk_i) begin
    if (cache_yumi_o) begin
      resp_data_r <= cache_data_i;
      resp_src_r  <= cache_src_i;
    end
  end

  // the cache completes requests one at a time in FIFO order,
  // so the response order matches the request order
  assign resp_v_o    = resp_v_r;
  assign resp_data_o = resp_data_r;
  assign resp_src_o  = resp_src_r;

endmodule

//--- verilog/vcache_cache.sv
// direct-mapped write-back, write-allocate cache
// serves loads, stores and the add/or/swap atomics one request at a
// time; misses write back a dirty victim and fetch the block over a
// whole-block dma port with one transaction outstanding

`timescale 1ns/1ns
`include "vcache_defines.svh"

module vcache_cache (
  input  logic                                clk_i
  , input  logic                              reset_i

  // request from the FIFO head, popped with yumi_o
  , input  logic                              v_i
  , input  logic [`VCACHE_REQ_WIDTH-1:0]      data_i
  , output logic                              yumi_o

  // result to the link adapter
  , output logic                              v_o
  , output logic [`VCACHE_DATA_WIDTH-1:0]     data_o
  , output logic [`VCACHE_SRC_WIDTH-1:0]      src_o
  , input  logic                              yumi_i

  // block dma
  , output logic                              dma_v_o
  , output logic                              dma_write_o
  , output logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_addr_o
  , output logic [`VCACHE_BLOCK_WIDTH-1:0]    dma_data_o
  , input  logic                              dma_yumi_i
  , input  logic                              dma_data_v_i
  , input  logic [`VCACHE_BLOCK_WIDTH-1:0]    dma_data_i
);

  import vcache_pkg::*;

  localparam int offset_bits_lp = $clog2(`VCACHE_BLOCK_WORDS);
  localparam int index_bits_lp  = $clog2(`VCACHE_SETS);
  localparam int tag_bits_lp    = `VCACHE_ADDR_WIDTH - index_bits_lp - offset_bits_lp;
  localparam int op_bits_lp     = $bits(vcache_opcode_e);

  vcache_state_e                 state_r;

  // current request
  vcache_opcode_e                op_r;
  logic [`VCACHE_ADDR_WIDTH-1:0] addr_r;
  logic [`VCACHE_DATA_WIDTH-1:0] wdata_r;
  logic [`VCACHE_SRC_WIDTH-1:0]  src_r;
  logic [`VCACHE_DATA_WIDTH-1:0] result_r;

  // line state and storage
  logic [`VCACHE_SETS-1:0]       valid_r;
  logic [`VCACHE_SETS-1:0]       dirty_r;
  logic [tag_bits_lp-1:0]        tag_r   [`VCACHE_SETS];
  logic [`VCACHE_BLOCK_WIDTH-1:0] block_r [`VCACHE_SETS];

  logic [offset_bits_lp-1:0]     offset;
  logic [index_bits_lp-1:0]      index;
  logic [tag_bits_lp-1:0]        tag;
  logic                          hit;
  logic                          write_op;
  logic [`VCACHE_DATA_WIDTH-1:0] old_word;
  logic [`VCACHE_DATA_WIDTH-1:0] new_word;
  logic [`VCACHE_DATA_WIDTH-1:0] resp_word;

  // address split: | tag | index | offset |
  assign offset = addr_r[0 +: offset_bits_lp];
  assign index  = addr_r[offset_bits_lp +: index_bits_lp];
  assign tag    = addr_r[`VCACHE_ADDR_WIDTH-1 -: tag_bits_lp];

  assign hit      = valid_r[index] & (tag_r[index] == tag);
  assign write_op = (op_r != OP_LW);
  assign old_word = block_r[index][offset*`VCACHE_DATA_WIDTH +: `VCACHE_DATA_WIDTH];

  // word update and returned value per opcode
  always_comb begin
    new_word  = old_word;
    resp_word = old_word;
    case (op_r)
      OP_SW: begin
        new_word  = wdata_r;
        resp_word = '0;
      end
      OP_AMOADD:  new_word = old_word + wdata_r;
      OP_AMOOR:   new_word = old_word | wdata_r;
      OP_AMOSWAP: new_word = wdata_r;
      default:    new_word = old_word;
    endcase
  end

  // controller and line state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          if (v_i) state_r <= LOOKUP;
        end
        LOOKUP: begin
          if (hit) begin
            state_r <= RESPOND;
            if (write_op) dirty_r[index] <= 1'b1;
          end else if (valid_r[index] & dirty_r[index]) begin
            state_r <= EVICT;
          end else begin
            state_r <= FILL_REQ;
          end
        end
        EVICT: begin
          if (dma_yumi_i) begin
            state_r        <= FILL_REQ;
            dirty_r[index] <= 1'b0;
          end
        end
        FILL_REQ: begin
          if (dma_yumi_i) state_r <= FILL_WAIT;
        end
        // refilled line goes back through lookup and hits
        FILL_WAIT: begin
          if (dma_data_v_i) begin
            state_r        <= LOOKUP;
            valid_r[index] <= 1'b1;
          end
        end
        RESPOND: begin
          if (yumi_i) state_r <= IDLE;
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  // request capture, line data and result
  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      op_r    <= vcache_opcode_e'(data_i[`VCACHE_REQ_WIDTH-1 -: op_bits_lp]);
      addr_r  <= data_i[`VCACHE_DATA_WIDTH+`VCACHE_SRC_WIDTH +: `VCACHE_ADDR_WIDTH];
      wdata_r <= data_i[`VCACHE_SRC_WIDTH +: `VCACHE_DATA_WIDTH];
      src_r   <= data_i[0 +: `VCACHE_SRC_WIDTH];
    end
    if ((state_r == LOOKUP) && hit) begin
      result_r <= resp_word;
      if (write_op) begin
        block_r[index][offset*`VCACHE_DATA_WIDTH +: `VCACHE_DATA_WIDTH] <= new_word;
      end
    end
    if ((state_r == FILL_WAIT) && dma_data_v_i) begin
      block_r[index] <= dma_data_i;
      tag_r[index]   <= tag;
    end
  end

  // pop the FIFO only when a new request is taken
  assign yumi_o = (state_r == IDLE) & v_i;

  assign v_o    = (state_r == RESPOND);
  assign data_o = result_r;
  assign src_o  = src_r;

  // victim write-back uses the stored tag, fill uses the request tag
  assign dma_v_o     = (state_r == EVICT) | (state_r == FILL_REQ);
  assign dma_write_o = (state_r == EVICT);
  assign dma_addr_o  = (state_r == EVICT) ? {tag_r[index], index} : {tag, index};
  assign dma_data_o  = block_r[index];

endmodule

//--- verilog/vcache_tile.sv
// vertical cache tile
// registers the distributed reset and the tile coordinates, bumps y
// for the next tile, and chains the link adapter, the request FIFO
// and the cache; cache misses leave on the block dma port

`timescale 1ns/1ns
`include "vcache_defines.svh"

module vcache_tile (
  input  logic                                clk_i
  , input  logic                              reset_i
  , output logic                              reset_o

  // network requests
  , input  logic                              req_v_i
  , input  vcache_pkg::vcache_opcode_e        req_op_i
  , input  logic [`VCACHE_ADDR_WIDTH-1:0]     req_addr_i
  , input  logic [`VCACHE_DATA_WIDTH-1:0]     req_data_i
  , input  logic [`VCACHE_SRC_WIDTH-1:0]      req_src_i
  , output logic                              req_ready_o

  // network responses
  , output logic                              resp_v_o
  , output logic [`VCACHE_DATA_WIDTH-1:0]     resp_data_o
  , output logic [`VCACHE_SRC_WIDTH-1:0]      resp_src_o
  , input  logic                              resp_yumi_i

  // block dma
  , output logic                              dma_v_o
  , output logic                              dma_write_o
  , output logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_addr_o
  , output logic [`VCACHE_BLOCK_WIDTH-1:0]    dma_data_o
  , input  logic                              dma_yumi_i
  , input  logic                              dma_data_v_i
  , input  logic [`VCACHE_BLOCK_WIDTH-1:0]    dma_data_i

  // tile coordinates
  , input  logic [`VCACHE_CORD_WIDTH-1:0]     global_x_i
  , input  logic [`VCACHE_CORD_WIDTH-1:0]     global_y_i
  , output logic [`VCACHE_CORD_WIDTH-1:0]     global_x_o
  , output logic [`VCACHE_CORD_WIDTH-1:0]     global_y_o
);

  logic                          reset_r;
  logic [`VCACHE_CORD_WIDTH-1:0] global_x_r;
  logic [`VCACHE_CORD_WIDTH-1:0] global_y_r;

  // link adapter to FIFO
  logic                          fifo_v;
  logic                          fifo_ready;
  logic [`VCACHE_REQ_WIDTH-1:0]  fifo_data;

  // FIFO head to cache
  logic                          cache_req_v;
  logic [`VCACHE_REQ_WIDTH-1:0]  cache_req_data;
  logic                          cache_req_yumi;

  // cache results back to the adapter
  logic                          cache_v;
  logic [`VCACHE_DATA_WIDTH-1:0] cache_data;
  logic [`VCACHE_SRC_WIDTH-1:0]  cache_src;
  logic                          cache_yumi;

  // every block below runs from the registered reset
  always_ff @(posedge clk_i) begin
    reset_r    <= reset_i;
    global_x_r <= global_x_i;
    global_y_r <= global_y_i;
  end

  assign reset_o    = reset_r;
  assign global_x_o = global_x_r;
  // next tile down the column
  assign global_y_o = `VCACHE_CORD_WIDTH'(global_y_r + 1'b1);

  vcache_link_to_cache link_to_cache (
    .clk_i(clk_i)
    ,.reset_i(reset_r)
    ,.req_v_i(req_v_i)
    ,.req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_src_i(req_src_i)
    ,.req_ready_o(req_ready_o)
    ,.fifo_v_o(fifo_v)
    ,.fifo_data_o(fifo_data)
    ,.fifo_ready_i(fifo_ready)
    ,.cache_v_i(cache_v)
    ,.cache_data_i(cache_data)
    ,.cache_src_i(cache_src)
    ,.cache_yumi_o(cache_yumi)
    ,.resp_v_o(resp_v_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_src_o(resp_src_o)
    ,.resp_yumi_i(resp_yumi_i)
  );

  vcache_req_fifo #(
    .width_p(`VCACHE_REQ_WIDTH)
    ,.els_p(`VCACHE_FIFO_ELS)
  ) req_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_r)
    ,.v_i(fifo_v)
    ,.data_i(fifo_data)
    ,.ready_o(fifo_ready)
    ,.v_o(cache_req_v)
    ,.data_o(cache_req_data)
    ,.yumi_i(cache_req_yumi)
  );

  vcache_cache cache (
    .clk_i(clk_i)
    ,.reset_i(reset_r)
    ,.v_i(cache_req_v)
    ,.data_i(cache_req_data)
    ,.yumi_o(cache_req_yumi)
    ,.v_o(cache_v)
    ,.data_o(cache_data)
    ,.src_o(cache_src)
    ,.yumi_i(cache_yumi)
    ,.dma_v_o(dma_v_o)
    ,.dma_write_o(dma_write_o)
    ,.dma_addr_o(dma_addr_o)
    ,.dma_data_o(dma_data_o)
    ,.dma_yumi_i(dma_yumi_i)
    ,.dma_data_v_i(dma_data_v_i)
    ,.dma_data_i(dma_data_i)
  );

endmodule

//--- bench/vcache_clock_gen.sv
// testbench clock and reset generator
// 100 ns clock, reset held high over the first 4 rising edges and
// released between a falling and a rising edge

`timescale 1ns/1ns

module vcache_clock_gen (
  output logic clk_o
  , output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // rising edges at 50, 150, 250, 350; release at 425
  initial begin
    reset_o = 1'b1;
    #425 reset_o = 1'b0;
  end

endmodule

//--- bench/vcache_tile_tb.sv
// testbench for the vertical cache tile
// random loads, stores and atomics against a flat memory model, a
// block dma responder with random delays, random response
// back-pressure and a final sweep over every touched address

`timescale 1ns/1ns
`include "vcache_defines.svh"

module vcache_tile_tb;

  import vcache_pkg::*;

  localparam int timeout_cycles_lp = 400;

  logic clk;
  logic reset;
  logic reset_o;
  logic req_v_i;
  vcache_opcode_e req_op_i;
  logic [`VCACHE_ADDR_WIDTH-1:0] req_addr_i;
  logic [`VCACHE_DATA_WIDTH-1:0] req_data_i;
  logic [`VCACHE_SRC_WIDTH-1:0] req_src_i;
  logic req_ready_o;
  logic resp_v_o;
  logic [`VCACHE_DATA_WIDTH-1:0] resp_data_o;
  logic [`VCACHE_SRC_WIDTH-1:0] resp_src_o;
  logic resp_yumi_i;
  logic dma_v_o;
  logic dma_write_o;
  logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_addr_o;
  logic [`VCACHE_BLOCK_WIDTH-1:0] dma_data_o;
  logic dma_yumi_i;
  logic dma_data_v_i;
  logic [`VCACHE_BLOCK_WIDTH-1:0] dma_data_i;
  logic [`VCACHE_CORD_WIDTH-1:0] global_x_i;
  logic [`VCACHE_CORD_WIDTH-1:0] global_y_i;
  logic [`VCACHE_CORD_WIDTH-1:0] global_x_o;
  logic [`VCACHE_CORD_WIDTH-1:0] global_y_o;

  // reference memory in request order, and the backing store behind dma
  logic [`VCACHE_DATA_WIDTH-1:0] model_mem [1 << `VCACHE_ADDR_WIDTH];
  logic [`VCACHE_DATA_WIDTH-1:0] dma_mem [1 << `VCACHE_ADDR_WIDTH];
  logic touched [1 << `VCACHE_ADDR_WIDTH];

  logic [`VCACHE_DATA_WIDTH-1:0] exp_data_q [$];
  logic [`VCACHE_SRC_WIDTH-1:0] exp_src_q [$];

  logic [31:0] stim_lfsr;
  logic [31:0] resp_lfsr;
  logic [31:0] dma_lfsr;
  logic hold_resp;
  int error_count;
  int timeout_count;

  vcache_clock_gen clock_gen (
    .clk_o(clk)
    ,.reset_o(reset)
  );

  vcache_tile dut_i (
    .clk_i(clk), .reset_i(reset), .reset_o(reset_o)
    ,.req_v_i(req_v_i), .req_op_i(req_op_i), .req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i), .req_src_i(req_src_i), .req_ready_o(req_ready_o)
    ,.resp_v_o(resp_v_o), .resp_data_o(resp_data_o), .resp_src_o(resp_src_o)
    ,.resp_yumi_i(resp_yumi_i)
    ,.dma_v_o(dma_v_o), .dma_write_o(dma_write_o), .dma_addr_o(dma_addr_o)
    ,.dma_data_o(dma_data_o), .dma_yumi_i(dma_yumi_i)
    ,.dma_data_v_i(dma_data_v_i), .dma_data_i(dma_data_i)
    ,.global_x_i(global_x_i), .global_y_i(global_y_i)
    ,.global_x_o(global_x_o), .global_y_o(global_y_o)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], state[0]};
      state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    end
    return value;
  endfunction

  // power-on memory contents, a function of the whole word address
  function automatic logic [31:0] init_word(input logic [`VCACHE_ADDR_WIDTH-1:0] addr);
    return 32'hA5C3_0000 ^ ({22'b0, addr} * 32'h9E37_79B1);
  endfunction

  task automatic send_request(input vcache_opcode_e op, input logic [9:0] addr,
                              input logic [31:0] data, input logic [3:0] src);
    int waited;
    logic [31:0] old;
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_src_i  = src;
    waited = 0;
    while (!req_ready_o && waited < timeout_cycles_lp) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready_o) begin
      timeout_count++;
      $display("timeout: request to address %0d was never accepted", addr);
    end else begin
      // accepted at the coming rising edge, apply it to the model now
      old = model_mem[addr];
      touched[addr] = 1'b1;
      case (op)
        OP_LW: exp_data_q.push_back(old);
        OP_SW: begin
          exp_data_q.push_back('0);
          model_mem[addr] = data;
        end
        OP_AMOADD: begin
          exp_data_q.push_back(old);
          model_mem[addr] = old + data;
        end
        OP_AMOOR: begin
          exp_data_q.push_back(old);
          model_mem[addr] = old | data;
        end
        default: begin
          exp_data_q.push_back(old);
          model_mem[addr] = data;
        end
      endcase
      exp_src_q.push_back(src);
    end
    @(negedge clk);
    req_v_i = 1'b0;
  endtask

  // small window, 4 tags per set, so hits, misses and dirty evictions mix
  function automatic logic [9:0] window_addr();
    return 10'(rand_bits(stim_lfsr, 7));
  endfunction

  task automatic send_random_request();
    logic [2:0] pick;
    vcache_opcode_e op;
    pick = 3'(rand_bits(stim_lfsr, 3));
    if (pick < 3'd4) op = OP_LW;
    else if (pick < 3'd6) op = OP_SW;
    else if (pick == 3'd6) op = OP_AMOADD;
    else op = (rand_bits(stim_lfsr, 1) != 0) ? OP_AMOOR : OP_AMOSWAP;
    send_request(op, window_addr(), rand_bits(stim_lfsr, 32), 4'(rand_bits(stim_lfsr, 4)));
    if (rand_bits(stim_lfsr, 2) == 0) @(negedge clk);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < 4 * timeout_cycles_lp) begin
      @(negedge clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      timeout_count++;
      $display("timeout: %0d responses never arrived", exp_data_q.size());
    end
  endtask

  // responses checked at the falling edge before the rising edge takes them
  initial begin
    logic prev_v;
    logic prev_taken;
    logic [31:0] prev_data;
    logic [3:0] prev_src;
    logic take;
    logic [31:0] exp_data;
    logic [3:0] exp_src;
    prev_v = 1'b0;
    prev_taken = 1'b0;
    forever begin
      @(negedge clk);
      if (prev_v && !prev_taken) begin
        assert (resp_v_o && resp_data_o == prev_data && resp_src_o == prev_src) else begin
          error_count++;
          $display("error %0t: response changed while stalled", $time);
        end
      end
      take = !reset && !hold_resp && (rand_bits(resp_lfsr, 2) != 0);
      resp_yumi_i = take;
      if (resp_v_o === 1'b1 && take) begin
        assert (exp_data_q.size() != 0) else begin
          error_count++;
          $display("error %0t: response with no request outstanding", $time);
        end
        if (exp_data_q.size() != 0) begin
          exp_data = exp_data_q.pop_front();
          exp_src = exp_src_q.pop_front();
          assert (resp_src_o == exp_src) else begin
            error_count++;
            $display("error %0t: source %0d, expected %0d", $time, resp_src_o, exp_src);
          end
          assert (resp_data_o == exp_data) else begin
            error_count++;
            $display("error %0t: data %h, expected %h", $time, resp_data_o, exp_data);
          end
        end
      end
      prev_v = (resp_v_o === 1'b1);
      prev_taken = take;
      prev_data = resp_data_o;
      prev_src = resp_src_o;
    end
  end

  // dma responder with random accept and return delays
  initial begin
    int delay;
    logic [7:0] blk;
    forever begin
      @(negedge clk);
      if (!reset && dma_v_o === 1'b1) begin
        delay = rand_bits(dma_lfsr, 2);
        for (int i = 0; i < delay; i++) @(negedge clk);
        blk = dma_addr_o;
        dma_yumi_i = 1'b1;
        if (dma_write_o) begin
          for (int w = 0; w < 4; w++) dma_mem[blk * 4 + w] = dma_data_o[w * 32 +: 32];
          @(negedge clk);
          dma_yumi_i = 1'b0;
        end else begin
          @(negedge clk);
          dma_yumi_i = 1'b0;
          delay = rand_bits(dma_lfsr, 2);
          for (int i = 0; i < delay; i++) @(negedge clk);
          for (int w = 0; w < 4; w++) dma_data_i[w * 32 +: 32] = dma_mem[blk * 4 + w];
          dma_data_v_i = 1'b1;
          @(negedge clk);
          dma_data_v_i = 1'b0;
        end
      end
    end
  end

  // registered reset and coordinates, checked every cycle
  initial begin
    logic last_reset;
    logic [`VCACHE_CORD_WIDTH-1:0] last_x;
    logic [`VCACHE_CORD_WIDTH-1:0] last_y;
    global_x_i = 6'd3;
    global_y_i = 6'd60;
    forever begin
      @(negedge clk);
      // values taken at the last rising edge
      last_reset = reset;
      last_x = global_x_i;
      last_y = global_y_i;
      global_x_i = global_x_i + 6'd5;
      global_y_i = global_y_i + 6'd1;
      // new inputs must not reach the outputs before the next rising edge
      #1;
      assert (reset_o === last_reset) else begin
        error_count++;
        $display("error %0t: reset_o %b, expected %b", $time, reset_o, last_reset);
      end
      assert (global_x_o === last_x && global_y_o === 6'(last_y + 1'b1)) else begin
        error_count++;
        $display("error %0t: coordinates %0d,%0d wrong", $time, global_x_o, global_y_o);
      end
    end
  end

  // reset input drops between edges, the registered copy lags behind
  initial begin
    @(negedge reset);
    #1;
    assert (reset_o === 1'b1) else begin
      error_count++;
      $display("error %0t: reset_o dropped together with reset_i", $time);
    end
  end

  initial begin
    int waited;
    req_v_i = 1'b0;
    req_op_i = OP_LW;
    req_addr_i = '0;
    req_data_i = '0;
    req_src_i = '0;
    resp_yumi_i = 1'b0;
    dma_yumi_i = 1'b0;
    dma_data_v_i = 1'b0;
    dma_data_i = '0;
    hold_resp = 1'b0;
    error_count = 0;
    timeout_count = 0;
    stim_lfsr = 32'd8;
    resp_lfsr = 32'd8;
    dma_lfsr = 32'd8;
    for (int a = 0; a < (1 << `VCACHE_ADDR_WIDTH); a++) begin
      model_mem[a] = init_word(a[9:0]);
      dma_mem[a] = init_word(a[9:0]);
      touched[a] = 1'b0;
    end

    waited = 0;
    while (reset && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (reset) begin
      timeout_count++;
      $display("timeout: reset was never released");
    end
    // idle tile after the registered reset drops
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      assert (resp_v_o === 1'b0 && dma_v_o === 1'b0) else begin
        error_count++;
        $display("error %0t: response or dma valid after reset", $time);
      end
    end

    for (int i = 0; i < 300; i++) send_random_request();

    // each atomic followed by a load of the same word
    for (int i = 0; i < 30; i++) begin
      logic [9:0] addr;
      addr = window_addr();
      send_request(vcache_opcode_e'(3'd2 + i % 3), addr, rand_bits(stim_lfsr, 32), 4'(i));
      send_request(OP_LW, addr, '0, 4'(i + 1));
    end

    // stall responses until the request buffer fills up
    wait_for_drain();
    hold_resp = 1'b1;
    for (int i = 0; i < 6; i++) send_request(OP_LW, window_addr(), '0, 4'(i));
    waited = 0;
    while (req_ready_o && waited < timeout_cycles_lp) begin
      @(negedge clk);
      waited++;
    end
    assert (!req_ready_o) else begin
      error_count++;
      $display("error %0t: req_ready_o stayed high with the buffer full", $time);
    end
    for (int i = 0; i < 10; i++) @(negedge clk);
    hold_resp = 1'b0;
    for (int i = 0; i < 40; i++) send_random_request();

    // final sweep over every touched word
    for (int a = 0; a < (1 << `VCACHE_ADDR_WIDTH); a++) begin
      if (touched[a]) send_request(OP_LW, a[9:0], '0, a[3:0]);
    end
    wait_for_drain();

    $display("checks done: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vcache_tile.f
+incdir+include
verilog/vcache_pkg.sv
verilog/vcache_req_fifo.sv
verilog/vcache_link_to_cache.sv
verilog/vcache_cache.sv
verilog/vcache_tile.sv
bench/vcache_clock_gen.sv
bench/vcache_tile_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vertical cache tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module vcache_tile_tb -f vcache_tile.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/Vvcache_tile_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
